// ==== hdl/vend_pkg.sv ====
`default_nettype none

package vend_pkg;

    ////////////////////////////////////////
    // widths with a meaning

    // amount in 100 won units, as shown on the display
    typedef logic [7:0] money_t;
    // one entry of the running total history
    typedef logic [6:0] credit_t;
    typedef logic [3:0] stock_t;
    // 0 is no product, 1 to 3 are products
    typedef logic [1:0] item_t;
    typedef logic [1:0] cursor_t;
    typedef logic [2:0] note_t;
    typedef logic [2:0] step_t;

    ////////////////////////////////////////
    // products

    localparam int      NUM_PROD    = 3;
    localparam cursor_t CURSOR_MAX  = 2'd2;
    // prices and initial stock, indexed by item id
    localparam credit_t PROD_PRICE [1:NUM_PROD] = '{7'd10, 7'd12, 7'd15};
    localparam stock_t  PROD_INIT  [1:NUM_PROD] = '{4'd5, 4'd1, 4'd0};
    localparam stock_t  STOCK_LIMIT = 4'd9;

    // coins and credit history
    localparam int      HIST_DEPTH = 9;
    localparam credit_t COIN_100   = 7'd1;
    localparam credit_t COIN_500   = 7'd5;
    localparam credit_t COIN_1000  = 7'd10;

    // piezo note codes, products sit above the coins
    localparam note_t NOTE_NONE      = 3'd0;
    localparam note_t NOTE_COIN_100  = 3'd1;
    localparam note_t NOTE_COIN_500  = 3'd2;
    localparam note_t NOTE_COIN_1000 = 3'd3;
    localparam note_t NOTE_PROD_BASE = 3'd3;
    localparam step_t STEP_LAST      = 3'd4;

    // timer defaults for the board clock
    localparam int HOLD_CYCLES_DEF   = 2_000_000;
    localparam int RETURN_CYCLES_DEF = 1_000_000;
    localparam int NOTE_STEP_DEF     = 100_000;

endpackage

`default_nettype wire

// ==== hdl/note_player.sv ====
`timescale 1ns/100ps
`default_nettype none

module note_player
    import vend_pkg::*;
#(
    parameter int NOTE_STEP = NOTE_STEP_DEF
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  note_t coin_note,
    input  wire  note_t sel_note,
    output note_t       note_state,
    output step_t       note_played
);

    localparam int STEP_W = $clog2(NOTE_STEP + 1);

    logic [STEP_W-1:0] step_cnt;
    note_t             req;

    // coin tone wins over a product tone
    assign req = (coin_note != NOTE_NONE) ? coin_note : sel_note;

    always_ff @(posedge clk) begin
        if (!rst) begin
            note_state  <= NOTE_NONE;
            note_played <= '0;
            step_cnt    <= '0;
        end else if (req != NOTE_NONE) begin
            // new request restarts the sequence
            note_state  <= req;
            note_played <= step_t'(1);
            step_cnt    <= '0;
        end else if (note_state != NOTE_NONE) begin
            if (step_cnt == STEP_W'(NOTE_STEP - 1)) begin
                step_cnt <= '0;
                if (note_played == STEP_LAST) begin
                    note_state  <= NOTE_NONE;
                    note_played <= '0;
                end else begin
                    note_played <= note_played + 1'b1;
                end
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/product_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module product_select
    import vend_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    input  wire      move_up,
    input  wire      move_down,
    input  wire      select_toggle,
    input  wire      prod_add,
    input  wire      admin_mode,
    input  wire      vend,
    output cursor_t  cursor_pos,
    output item_t    sel_item,
    output note_t    sel_note,
    output stock_t   stock_level
);

    // stock per product, indexed by item id
    stock_t stock [1:NUM_PROD];
    // product under the cursor
    item_t  cur_item;

    assign cur_item = item_t'(cursor_pos) + item_t'(1);

    ////////////////////////////////////////
    // cursor

    // clamps at both ends
    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor_pos <= '0;
        end else if (move_up && cursor_pos != '0) begin
            cursor_pos <= cursor_pos - 1'b1;
        end else if (move_down && cursor_pos != CURSOR_MAX) begin
            cursor_pos <= cursor_pos + 1'b1;
        end
    end

    ////////////////////////////////////////
    // selection and stock

    always_ff @(posedge clk) begin
        if (!rst) begin
            sel_item    <= '0;
            sel_note    <= NOTE_NONE;
            stock_level <= PROD_INIT[1];
            for (int i = 1; i <= NUM_PROD; i++) begin
                stock[i] <= PROD_INIT[i];
            end
        end else begin
            // note request lasts one cycle
            sel_note    <= NOTE_NONE;
            stock_level <= stock[cur_item];

            // same product again deselects it
            if (select_toggle) begin
                if (sel_item == cur_item) begin
                    sel_item <= '0;
                end else if (stock[cur_item] != '0) begin
                    sel_item <= cur_item;
                    sel_note <= NOTE_PROD_BASE + note_t'(cur_item);
                end
            end

            // restock only in admin mode
            if (prod_add && admin_mode && stock[cur_item] < STOCK_LIMIT) begin
                stock[cur_item] <= stock[cur_item] + 1'b1;
            end

            // purchase done in the ledger
            if (vend && sel_item != '0) begin
                stock[sel_item] <= stock[sel_item] - 1'b1;
                sel_item        <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/money_ledger.sv ====
`timescale 1ns/100ps
`default_nettype none

module money_ledger
    import vend_pkg::*;
#(
    parameter int HOLD_CYCLES   = HOLD_CYCLES_DEF,
    parameter int RETURN_CYCLES = RETURN_CYCLES_DEF
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  [2:0]  coin,
    input  wire         buy,
    input  wire         return_money,
    input  wire  item_t sel_item,
    output money_t      display_money,
    output logic        vend,
    output note_t       coin_note
);

    localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);
    localparam int RET_W  = $clog2(RETURN_CYCLES + 1);

    typedef enum logic [1:0] {
        DISP_TOTAL,
        DISP_HOLD,
        DISP_RETURN
    } disp_state_t;

    disp_state_t        disp_state;
    logic [HOLD_W-1:0]  hold_cnt;
    logic [RET_W-1:0]   ret_cnt;
    // hist[0] is the current credit, older totals below it
    credit_t            hist [HIST_DEPTH];
    // set after a purchase until the change is paid out
    logic               purchased;

    credit_t coin_val;
    note_t   coin_code;
    credit_t price;
    logic    can_buy;
    logic    older_empty;

    // one-hot coin decode, other patterns ignored
    always_comb begin
        case (coin)
            3'b100: begin
                coin_val  = COIN_100;
                coin_code = NOTE_COIN_100;
            end
            3'b010: begin
                coin_val  = COIN_500;
                coin_code = NOTE_COIN_500;
            end
            3'b001: begin
                coin_val  = COIN_1000;
                coin_code = NOTE_COIN_1000;
            end
            default: begin
                coin_val  = '0;
                coin_code = NOTE_NONE;
            end
        endcase
    end

    always_comb begin
        case (sel_item)
            2'd1:    price = PROD_PRICE[1];
            2'd2:    price = PROD_PRICE[2];
            2'd3:    price = PROD_PRICE[3];
            default: price = '0;
        endcase
    end

    // credit must be strictly above the price
    assign can_buy = (sel_item != '0) && (hist[0] > price);

    always_comb begin
        older_empty = 1'b1;
        for (int i = 1; i < HIST_DEPTH; i++) begin
            if (hist[i] != '0) begin
                older_empty = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // history, purchase and display

    always_ff @(posedge clk) begin
        if (!rst) begin
            disp_state    <= DISP_TOTAL;
            hold_cnt      <= '0;
            ret_cnt       <= '0;
            purchased     <= 1'b0;
            display_money <= '0;
            vend          <= 1'b0;
            coin_note     <= NOTE_NONE;
            for (int i = 0; i < HIST_DEPTH; i++) begin
                hist[i] <= '0;
            end
        end else begin
            vend      <= 1'b0;
            coin_note <= NOTE_NONE;

            case (disp_state)
                DISP_HOLD: begin
                    // coin value shown, then back to the total
                    if (hold_cnt == HOLD_W'(HOLD_CYCLES - 1)) begin
                        disp_state    <= DISP_TOTAL;
                        display_money <= money_t'(hist[0]);
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                DISP_RETURN: begin
                    if (ret_cnt == RET_W'(RETURN_CYCLES)) begin
                        ret_cnt <= '0;
                        if (!purchased) begin
                            // pop back to the previous total
                            for (int i = 0; i < HIST_DEPTH - 1; i++) begin
                                hist[i] <= hist[i+1];
                            end
                            hist[HIST_DEPTH-1] <= '0;
                            display_money      <= money_t'(hist[1]);
                            if (older_empty) begin
                                disp_state <= DISP_TOTAL;
                            end
                        end else if (hist[0] != '0) begin
                            // change paid one unit per step
                            hist[0]       <= hist[0] - 1'b1;
                            display_money <= money_t'(hist[0] - 1'b1);
                        end else begin
                            purchased  <= 1'b0;
                            disp_state <= DISP_TOTAL;
                        end
                    end else begin
                        ret_cnt <= ret_cnt + 1'b1;
                    end
                end
                default: ;
            endcase

            if (coin_code != NOTE_NONE) begin
                for (int i = HIST_DEPTH - 1; i > 0; i--) begin
                    hist[i] <= hist[i-1];
                end
                hist[0]       <= hist[0] + coin_val;
                display_money <= money_t'(coin_val);
                coin_note     <= coin_code;
                disp_state    <= DISP_HOLD;
                hold_cnt      <= '0;
            end else if (buy && can_buy) begin
                // older totals no longer mean anything
                for (int i = 1; i < HIST_DEPTH; i++) begin
                    hist[i] <= '0;
                end
                hist[0]       <= hist[0] - price;
                display_money <= money_t'(hist[0] - price);
                purchased     <= 1'b1;
                vend          <= 1'b1;
            end else if (return_money) begin
                display_money <= money_t'(hist[0]);
                disp_state    <= DISP_RETURN;
                ret_cnt       <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vend_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vend_top
    import vend_pkg::*;
#(
    parameter int HOLD_CYCLES   = HOLD_CYCLES_DEF,
    parameter int RETURN_CYCLES = RETURN_CYCLES_DEF,
    parameter int NOTE_STEP     = NOTE_STEP_DEF
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         move_up,
    input  wire         move_down,
    input  wire         select_toggle,
    input  wire         buy,
    input  wire  [2:0]  coin,
    input  wire         return_money,
    input  wire         prod_add,
    input  wire         admin_mode,
    output money_t      display_money,
    output note_t       note_state,
    output step_t       note_played,
    output stock_t      stock_level,
    output cursor_t     cursor_pos,
    output item_t       sel_item
);

    // links between the blocks
    logic  vend;
    note_t coin_note;
    note_t sel_note;

    product_select u_select (
        .clk           (clk),
        .rst           (rst),
        .move_up       (move_up),
        .move_down     (move_down),
        .select_toggle (select_toggle),
        .prod_add      (prod_add),
        .admin_mode    (admin_mode),
        .vend          (vend),
        .cursor_pos    (cursor_pos),
        .sel_item      (sel_item),
        .sel_note      (sel_note),
        .stock_level   (stock_level)
    );

    money_ledger #(
        .HOLD_CYCLES   (HOLD_CYCLES),
        .RETURN_CYCLES (RETURN_CYCLES)
    ) u_ledger (
        .clk           (clk),
        .rst           (rst),
        .coin          (coin),
        .buy           (buy),
        .return_money  (return_money),
        .sel_item      (sel_item),
        .display_money (display_money),
        .vend          (vend),
        .coin_note     (coin_note)
    );

    note_player #(
        .NOTE_STEP (NOTE_STEP)
    ) u_note (
        .clk         (clk),
        .rst         (rst),
        .coin_note   (coin_note),
        .sel_note    (sel_note),
        .note_state  (note_state),
        .note_played (note_played)
    );

endmodule

`default_nettype wire

// ==== tests/tb_vend.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vend
    import vend_pkg::*;
();

    localparam int HOLD = 6;
    localparam int RET  = 3;
    localparam int STEP = 4;

    localparam int BTN_UP   = 0;
    localparam int BTN_DOWN = 1;
    localparam int BTN_SEL  = 2;
    localparam int BTN_BUY  = 3;
    localparam int BTN_RET  = 4;
    localparam int BTN_ADD  = 5;

    logic       clk;
    logic       rst;
    logic       move_up;
    logic       move_down;
    logic       select_toggle;
    logic       buy;
    logic [2:0] coin;
    logic       return_money;
    logic       prod_add;
    logic       admin_mode;
    money_t     display_money;
    note_t      note_state;
    step_t      note_played;
    stock_t     stock_level;
    cursor_t    cursor_pos;
    item_t      sel_item;

    // reference model state
    cursor_t     m_cur;
    item_t       m_sel;
    stock_t      m_stock [1:3];
    credit_t     m_hist [HIST_DEPTH];
    logic        m_purchased;
    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          err_mark;

    vend_top #(
        .HOLD_CYCLES   (HOLD),
        .RETURN_CYCLES (RET),
        .NOTE_STEP     (STEP)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .move_up       (move_up),
        .move_down     (move_down),
        .select_toggle (select_toggle),
        .buy           (buy),
        .coin          (coin),
        .return_money  (return_money),
        .prod_add      (prod_add),
        .admin_mode    (admin_mode),
        .display_money (display_money),
        .note_state    (note_state),
        .note_played   (note_played),
        .stock_level   (stock_level),
        .cursor_pos    (cursor_pos),
        .sel_item      (sel_item)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [2:0] random_coin();
        logic [31:0] r;
        r = lcg_next();
        return 3'b100 >> ((r >> 16) % 3);
    endfunction

    function automatic credit_t coin_value(input logic [2:0] c);
        case (c)
            3'b100:  return 7'd1;
            3'b010:  return 7'd5;
            3'b001:  return 7'd10;
            default: return 7'd0;
        endcase
    endfunction

    function automatic credit_t prod_price(input item_t item);
        case (item)
            2'd1:    return 7'd10;
            2'd2:    return 7'd12;
            2'd3:    return 7'd15;
            default: return 7'd0;
        endcase
    endfunction

    // move_up walks toward 0 and move_down toward 2
    function automatic cursor_t next_cursor(input cursor_t c, input logic up);
        if (up && c != 2'd0) begin
            return c - 2'd1;
        end else if (!up && c != 2'd2) begin
            return c + 2'd1;
        end
        return c;
    endfunction

    function automatic stock_t restocked(input stock_t s, input logic admin);
        return (admin && s < 4'd9) ? s + 4'd1 : s;
    endfunction

    function automatic stock_t cur_stock();
        return m_stock[item_t'(m_cur) + item_t'(1)];
    endfunction

    function automatic void toggle_selection();
        item_t here;
        here = item_t'(m_cur) + item_t'(1);
        if (m_sel == here) begin
            m_sel = '0;
        end else if (m_stock[here] != '0) begin
            m_sel = here;
        end
    endfunction

    function automatic void push_credit(input credit_t v);
        for (int i = HIST_DEPTH - 1; i > 0; i--) begin
            m_hist[i] = m_hist[i-1];
        end
        m_hist[0] = m_hist[0] + v;
    endfunction

    function automatic void pop_credit();
        for (int i = 0; i < HIST_DEPTH - 1; i++) begin
            m_hist[i] = m_hist[i+1];
        end
        m_hist[HIST_DEPTH-1] = '0;
    endfunction

    function automatic logic credit_empty();
        for (int i = 0; i < HIST_DEPTH; i++) begin
            if (m_hist[i] != '0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // vend only when credit is strictly above the price
    function automatic void apply_buy();
        credit_t price;
        price = prod_price(m_sel);
        if (m_sel != '0 && m_hist[0] > price) begin
            m_hist[0] = m_hist[0] - price;
            for (int i = 1; i < HIST_DEPTH; i++) begin
                m_hist[i] = '0;
            end
            m_stock[m_sel] = m_stock[m_sel] - 4'd1;
            m_sel = '0;
            m_purchased = 1'b1;
        end
    endfunction

    ////////////////////////////////////////
    // compares and waits

    task automatic check_money(input string name, input money_t got, input money_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_stock(input string name, input stock_t got, input stock_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic check_item(input string name, input item_t got, input item_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic check_cursor(input string name, input cursor_t got, input cursor_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic check_note(input string name, input note_t got, input note_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic check_step(input string name, input step_t got, input step_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic wait_money(input money_t exp, input int limit, input string what);
        int n;
        n = 0;
        while (display_money !== exp && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (display_money !== exp) begin
            errors++;
            $display("timeout: display_money never reached 0x%02h while %s", exp, what);
        end
    endtask

    task automatic wait_step(input step_t exp, input int limit);
        int n;
        n = 0;
        while (note_played !== exp && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (note_played !== exp) begin
            errors++;
            $display("timeout: note_played did not reach step %0d", exp);
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == err_mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    ////////////////////////////////////////
    // stimulus

    // one-cycle pulse that returns at the falling edge after the sample
    task automatic press(input int btn);
        @(posedge clk);
        case (btn)
            BTN_UP:   move_up       <= 1'b1;
            BTN_DOWN: move_down     <= 1'b1;
            BTN_SEL:  select_toggle <= 1'b1;
            BTN_BUY:  buy           <= 1'b1;
            BTN_RET:  return_money  <= 1'b1;
            default:  prod_add      <= 1'b1;
        endcase
        @(posedge clk);
        {move_up, move_down, select_toggle, buy, return_money, prod_add} <= '0;
        @(negedge clk);
    endtask

    task automatic move_to(input cursor_t target);
        logic up;
        while (m_cur != target) begin
            up = (m_cur > target);
            press(up ? BTN_UP : BTN_DOWN);
            m_cur = next_cursor(m_cur, up);
        end
        check_cursor("cursor_pos", cursor_pos, m_cur);
        @(negedge clk);
        check_stock("stock_level", stock_level, cur_stock());
    endtask

    task automatic add_coin(input logic [2:0] c);
        @(posedge clk);
        coin <= c;
        @(posedge clk);
        coin <= 3'b000;
        @(negedge clk);
        push_credit(coin_value(c));
        check_money("display_money", display_money, money_t'(coin_value(c)));
        wait_money(money_t'(m_hist[0]), HOLD + 4, "holding a coin value");
    endtask

    task automatic try_buy();
        press(BTN_BUY);
        apply_buy();
        check_money("display_money", display_money, money_t'(m_hist[0]));
        // stock and selection settle two cycles after the buy
        repeat (2) @(negedge clk);
        check_item("sel_item", sel_item, m_sel);
        check_stock("stock_level", stock_level, cur_stock());
    endtask

    task automatic pay_back();
        press(BTN_RET);
        check_money("display_money", display_money, money_t'(m_hist[0]));
        if (m_purchased) begin
            while (m_hist[0] != '0) begin
                m_hist[0] = m_hist[0] - 7'd1;
                wait_money(money_t'(m_hist[0]), 2 * (RET + 1) + 2, "paying change");
            end
            m_purchased = 1'b0;
        end else begin
            while (!credit_empty()) begin
                pop_credit();
                wait_money(money_t'(m_hist[0]), 2 * (RET + 1) + 2, "returning coins");
            end
        end
        repeat (2 * (RET + 1)) @(negedge clk);
        check_money("display_money", display_money, '0);
    endtask

    initial begin
        logic [31:0] r;
        note_t       exp_note;

        rst           = 1'b0;
        move_up       = 1'b0;
        move_down     = 1'b0;
        select_toggle = 1'b0;
        buy           = 1'b0;
        coin          = 3'b000;
        return_money  = 1'b0;
        prod_add      = 1'b0;
        admin_mode    = 1'b0;
        lcg_state     = 32'hfb93_1e2b;
        checks        = 0;
        errors        = 0;
        err_mark      = 0;
        m_cur         = '0;
        m_sel         = '0;
        m_purchased   = 1'b0;
        m_stock[1]    = 4'd5;
        m_stock[2]    = 4'd1;
        m_stock[3]    = 4'd0;
        for (int i = 0; i < HIST_DEPTH; i++) begin
            m_hist[i] = '0;
        end

        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);

        // 1 cursor clamping and the stock under the cursor
        check_money("display_money", display_money, '0);
        check_note("note_state", note_state, '0);
        check_step("note_played", note_played, '0);
        check_item("sel_item", sel_item, '0);
        check_cursor("cursor_pos", cursor_pos, '0);
        check_stock("stock_level", stock_level, cur_stock());
        repeat (12) begin
            r = lcg_next();
            press(r[31] ? BTN_UP : BTN_DOWN);
            m_cur = next_cursor(m_cur, r[31]);
            check_cursor("cursor_pos", cursor_pos, m_cur);
            @(negedge clk);
            check_stock("stock_level", stock_level, cur_stock());
        end
        end_test(1, "cursor and stock");

        // 2 an empty product is refused and a stocked one plays its tone
        move_to(2'd2);
        press(BTN_SEL);
        toggle_selection();
        check_item("sel_item", sel_item, m_sel);
        move_to(2'd0);
        press(BTN_SEL);
        toggle_selection();
        check_item("sel_item", sel_item, m_sel);
        exp_note = 3'd3 + note_t'(m_sel);
        for (int s = 1; s <= 4; s++) begin
            wait_step(step_t'(s), 2 * STEP + 2);
            check_note("note_state", note_state, exp_note);
        end
        wait_step('0, 2 * STEP + 2);
        check_note("note_state", note_state, '0);
        press(BTN_SEL);
        toggle_selection();
        check_item("sel_item", sel_item, m_sel);
        end_test(2, "selection");

        // 3
        repeat (4) add_coin(random_coin());
        end_test(3, "coins");

        // 4 equal credit is refused before a real purchase and change
        pay_back();
        add_coin(3'b001);
        press(BTN_SEL);
        toggle_selection();
        check_item("sel_item", sel_item, m_sel);
        try_buy();
        add_coin(random_coin());
        try_buy();
        pay_back();
        end_test(4, "purchase and change");

        // 5
        repeat (4) add_coin(random_coin());
        pay_back();
        end_test(5, "return without purchase");

        // 6 restock only in admin mode and only up to the limit
        move_to(2'd1);
        press(BTN_ADD);
        m_stock[2] = restocked(m_stock[2], 1'b0);
        @(negedge clk);
        check_stock("stock_level", stock_level, cur_stock());
        @(posedge clk);
        admin_mode <= 1'b1;
        repeat (10) begin
            press(BTN_ADD);
            m_stock[2] = restocked(m_stock[2], 1'b1);
            @(negedge clk);
            check_stock("stock_level", stock_level, cur_stock());
        end
        @(posedge clk);
        admin_mode <= 1'b0;
        end_test(6, "restock");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/vend_pkg.sv
hdl/note_player.sv
hdl/product_select.sv
hdl/money_ledger.sv
hdl/vend_top.sv
tests/tb_vend.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_vend
FLIST    = src.f
SIMFLAGS = --binary --timing -Wno-fatal --top-module $(TOP)
OBJDIR   = obj_dir

BIN  = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIMFLAGS) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJDIR)
